// ==== hw/pe_pkg.sv ====
// Widths, word types and command codes shared by the processing element RTL and its testbench.
package pe_pkg;

        localparam int WORD_BITS      = 32;     // offsets held by one memory word.
        localparam int BIT_INDEX_BITS = 5;      // low offset bits that pick a bit inside a word.

        typedef logic [WORD_BITS-1:0]      pe_word_t;
        typedef logic [BIT_INDEX_BITS-1:0] pe_bit_index_t;
        typedef logic [1:0]                pe_command_t;

        localparam pe_command_t CMD_COMPUTE = 2'd0;     // mark first, first + step, ... up to last.
        localparam pe_command_t CMD_CLEAR   = 2'd1;     // zero every memory word.
        localparam pe_command_t CMD_READ    = 2'd2;     // return one word, code 3 never completes.

        localparam int DEFAULT_STEP_WIDTH   = 11;
        localparam int DEFAULT_OFFSET_WIDTH = 14;

endpackage

// ==== hw/command_sequencer.sv ====
// Decodes a held start into engine begin pulses and active levels, and returns command_done.
module command_sequencer (
        input  logic                clock,
        input  logic                reset_n,
        input  logic                start,
        input  pe_pkg::pe_command_t command,
        input  logic                compute_done,
        input  logic                clear_done,
        input  logic                read_done,
        output logic                begin_compute,
        output logic                begin_clear,
        output logic                begin_read,
        output logic                compute_active,
        output logic                clear_active,
        output logic                read_active,
        output logic                command_done
);
        import pe_pkg::*;

        logic start_q;          // start one cycle late, low during the first cycle of a command.
        logic first_cycle;

        assign first_cycle    = start & ~start_q;
        assign compute_active = start & (command == CMD_COMPUTE);
        assign clear_active   = start & (command == CMD_CLEAR);
        assign read_active    = start & (command == CMD_READ);

        always_ff @(posedge clock) begin
                if (!reset_n) begin
                        start_q       <= 1'b0;
                        begin_compute <= 1'b0;
                        begin_clear   <= 1'b0;
                        begin_read    <= 1'b0;
                        command_done  <= 1'b0;
                end else begin
                        start_q       <= start;
                        begin_compute <= first_cycle & compute_active;
                        begin_clear   <= first_cycle & clear_active;
                        begin_read    <= first_cycle & read_active;
                        command_done  <= compute_done | clear_done | read_done;
                end
        end

        // the engines rely on the command staying put until start is dropped.
        assert property (@(posedge clock) disable iff (!reset_n)
                start && start_q |-> $stable(command));

endmodule

// ==== hw/mark_engine.sv ====
// Walks the offsets of a compute command and ORs the marked bits into memory one word at a time.
module mark_engine #(
        parameter int  STEP_WIDTH    = pe_pkg::DEFAULT_STEP_WIDTH,
        parameter int  OFFSET_WIDTH  = pe_pkg::DEFAULT_OFFSET_WIDTH,
        localparam int ADDRESS_WIDTH = OFFSET_WIDTH - pe_pkg::BIT_INDEX_BITS
) (
        input  logic                     clock,
        input  logic                     reset_n,
        input  logic                     begin_compute,
        input  logic                     compute_active,
        input  logic [STEP_WIDTH-1:0]    step,
        input  logic [OFFSET_WIDTH-1:0]  first_offset,
        input  logic [OFFSET_WIDTH-1:0]  last_offset,
        input  pe_pkg::pe_word_t         read_data,
        output logic [ADDRESS_WIDTH-1:0] read_address,
        output logic                     write_enable,
        output logic [ADDRESS_WIDTH-1:0] write_address,
        output pe_pkg::pe_word_t         write_data,
        output logic                     compute_done
);
        import pe_pkg::*;

        logic [OFFSET_WIDTH:0] offset;          // spare top bit so offset + step never wraps.
        pe_bit_index_t         bit_index;
        logic                  in_range;
        logic                  same_word;
        logic                  gather;          // offset still falls in the word being read.
        logic                  flush;           // word finished and its memory data is here.
        pe_word_t              word_mask;       // bits marked so far in the current word.
        logic                  read_issued;
        logic                  data_available;

        assign bit_index = offset[BIT_INDEX_BITS-1:0];
        assign in_range  = offset <= {1'b0, last_offset};
        assign same_word = offset[OFFSET_WIDTH-1:BIT_INDEX_BITS] == read_address;
        assign gather    = in_range & same_word;
        assign flush     = data_available & ~gather;

        // only the write made after the offset has passed last_offset ends the command.
        assign compute_done = write_enable & ~in_range;

        always_ff @(posedge clock) begin
                if (!reset_n) begin
                        offset         <= '0;
                        read_issued    <= 1'b0;
                        data_available <= 1'b0;
                        write_enable   <= 1'b0;
                end else if (begin_compute) begin
                        offset         <= {1'b0, first_offset};
                        read_issued    <= 1'b1;
                        data_available <= 1'b0;
                        write_enable   <= 1'b0;
                end else if (compute_active) begin
                        read_issued    <= flush & in_range;     // next word goes out with the write.
                        data_available <= read_issued | (data_available & gather);
                        write_enable   <= flush;
                        if (gather) begin
                                offset <= offset + (OFFSET_WIDTH + 1)'(step);
                        end
                end else begin
                        read_issued    <= 1'b0;
                        data_available <= 1'b0;
                        write_enable   <= 1'b0;
                end
        end

        always_ff @(posedge clock) begin
                if (begin_compute) begin
                        read_address <= first_offset[OFFSET_WIDTH-1:BIT_INDEX_BITS];
                        word_mask    <= '0;
                end else if (flush) begin
                        read_address <= offset[OFFSET_WIDTH-1:BIT_INDEX_BITS];
                        word_mask    <= '0;
                end else if (gather) begin
                        word_mask <= word_mask | (pe_word_t'(1) << bit_index);
                end
                if (flush) begin
                        write_address <= read_address;
                        write_data    <= read_data | word_mask;     // marks accumulate on old bits.
                end
        end

        // a zero step would keep the offset on its first word forever.
        assert property (@(posedge clock) disable iff (!reset_n)
                compute_active |-> step != '0);

endmodule

// ==== hw/clear_engine.sv ====
// Sweeps every word address once, writing zero, to carry out the clear command.
module clear_engine #(
        parameter int  OFFSET_WIDTH  = pe_pkg::DEFAULT_OFFSET_WIDTH,
        localparam int ADDRESS_WIDTH = OFFSET_WIDTH - pe_pkg::BIT_INDEX_BITS
) (
        input  logic                     clock,
        input  logic                     reset_n,
        input  logic                     begin_clear,
        input  logic                     clear_active,
        output logic                     write_enable,
        output logic [ADDRESS_WIDTH-1:0] write_address,
        output logic                     clear_done
);
        logic last_address;

        assign last_address = &write_address;
        assign clear_done   = write_enable & last_address;  // raised with the final write.

        always_ff @(posedge clock) begin
                if (!reset_n) begin
                        write_enable <= 1'b0;
                end else begin
                        write_enable <= begin_clear | (clear_active & write_enable & ~last_address);
                end
        end

        always_ff @(posedge clock) begin
                if (begin_clear) begin
                        write_address <= '0;
                end else if (write_enable) begin
                        write_address <= write_address + 1'b1;
                end
        end

endmodule

// ==== hw/word_reader.sv ====
// Issues the single word read of the read command and holds the returned word for the host.
module word_reader #(
        parameter int  OFFSET_WIDTH  = pe_pkg::DEFAULT_OFFSET_WIDTH,
        localparam int ADDRESS_WIDTH = OFFSET_WIDTH - pe_pkg::BIT_INDEX_BITS
) (
        input  logic                     clock,
        input  logic                     reset_n,
        input  logic                     begin_read,
        input  logic                     read_active,
        input  logic [ADDRESS_WIDTH-1:0] word_address,
        input  pe_pkg::pe_word_t         memory_data,
        output logic [ADDRESS_WIDTH-1:0] read_address,
        output logic                     read_done,
        output pe_pkg::pe_word_t         read_data
);
        logic request;          // address is on the memory read port.
        logic data_ready;       // memory output now holds the addressed word.

        always_ff @(posedge clock) begin
                if (!reset_n) begin
                        request    <= 1'b0;
                        data_ready <= 1'b0;
                        read_done  <= 1'b0;
                        read_data  <= '0;
                end else begin
                        request    <= begin_read;
                        data_ready <= request & read_active;
                        read_done  <= data_ready & read_active;
                        if (data_ready & read_active) begin
                                read_data <= memory_data;
                        end
                end
        end

        always_ff @(posedge clock) begin
                if (begin_read) begin
                        read_address <= word_address;
                end
        end

endmodule

// ==== hw/bit_memory.sv ====
// Simple-dual-port word memory shared by the engines, with one cycle of read latency.
module bit_memory #(
        parameter int  OFFSET_WIDTH  = pe_pkg::DEFAULT_OFFSET_WIDTH,
        localparam int ADDRESS_WIDTH = OFFSET_WIDTH - pe_pkg::BIT_INDEX_BITS
) (
        input  logic                     clock,
        input  logic                     compute_active,
        input  logic                     mark_write_enable,
        input  logic [ADDRESS_WIDTH-1:0] mark_write_address,
        input  pe_pkg::pe_word_t         mark_write_data,
        input  logic                     clear_write_enable,
        input  logic [ADDRESS_WIDTH-1:0] clear_write_address,
        input  logic [ADDRESS_WIDTH-1:0] mark_read_address,
        input  logic [ADDRESS_WIDTH-1:0] reader_read_address,
        output pe_pkg::pe_word_t         read_data
);
        import pe_pkg::*;

        localparam int DEPTH = 2 ** ADDRESS_WIDTH;

        pe_word_t                 memory [DEPTH];
        logic                     write_enable;
        logic [ADDRESS_WIDTH-1:0] write_address;
        pe_word_t                 write_data;
        logic [ADDRESS_WIDTH-1:0] read_address;

        assign write_enable  = mark_write_enable | clear_write_enable;
        assign write_address = mark_write_enable ? mark_write_address : clear_write_address;
        assign write_data    = mark_write_enable ? mark_write_data : '0;    // a clear writes zero.
        assign read_address  = compute_active ? mark_read_address : reader_read_address;

        always_ff @(posedge clock) begin
                if (write_enable) begin
                        memory[write_address] <= write_data;
                end
                read_data <= memory[read_address];
        end

        // only one command runs at a time, so the engines never write together.
        assert property (@(posedge clock) mark_write_enable |-> !clear_write_enable);

endmodule

// ==== hw/processing_element.sv ====
// Top level of the bit-marking processing element, connecting the sequencer, engines and memory.
module processing_element #(
        parameter int  STEP_WIDTH    = pe_pkg::DEFAULT_STEP_WIDTH,
        parameter int  OFFSET_WIDTH  = pe_pkg::DEFAULT_OFFSET_WIDTH,
        localparam int ADDRESS_WIDTH = OFFSET_WIDTH - pe_pkg::BIT_INDEX_BITS
) (
        input  logic                    clock,
        input  logic                    reset_n,
        input  logic                    start,
        input  pe_pkg::pe_command_t     command,
        input  logic [STEP_WIDTH-1:0]   argument_1,
        input  logic [OFFSET_WIDTH-1:0] argument_2,
        input  logic [OFFSET_WIDTH-1:0] argument_3,
        output pe_pkg::pe_word_t        memory_read_data,
        output logic                    command_done
);
        import pe_pkg::*;

        logic                     begin_compute;
        logic                     begin_clear;
        logic                     begin_read;
        logic                     compute_active;
        logic                     clear_active;
        logic                     read_active;
        logic                     compute_done;
        logic                     clear_done;
        logic                     read_done;
        logic [ADDRESS_WIDTH-1:0] mark_read_address;
        logic                     mark_write_enable;
        logic [ADDRESS_WIDTH-1:0] mark_write_address;
        pe_word_t                 mark_write_data;
        logic                     clear_write_enable;
        logic [ADDRESS_WIDTH-1:0] clear_write_address;
        logic [ADDRESS_WIDTH-1:0] reader_read_address;
        pe_word_t                 memory_data;

        command_sequencer u_command_sequencer (
                .clock          (clock),
                .reset_n        (reset_n),
                .start          (start),
                .command        (command),
                .compute_done   (compute_done),
                .clear_done     (clear_done),
                .read_done      (read_done),
                .begin_compute  (begin_compute),
                .begin_clear    (begin_clear),
                .begin_read     (begin_read),
                .compute_active (compute_active),
                .clear_active   (clear_active),
                .read_active    (read_active),
                .command_done   (command_done)
        );

        mark_engine #(
                .STEP_WIDTH   (STEP_WIDTH),
                .OFFSET_WIDTH (OFFSET_WIDTH)
        ) u_mark_engine (
                .clock          (clock),
                .reset_n        (reset_n),
                .begin_compute  (begin_compute),
                .compute_active (compute_active),
                .step           (argument_1),
                .first_offset   (argument_2),
                .last_offset    (argument_3),
                .read_data      (memory_data),
                .read_address   (mark_read_address),
                .write_enable   (mark_write_enable),
                .write_address  (mark_write_address),
                .write_data     (mark_write_data),
                .compute_done   (compute_done)
        );

        clear_engine #(
                .OFFSET_WIDTH (OFFSET_WIDTH)
        ) u_clear_engine (
                .clock         (clock),
                .reset_n       (reset_n),
                .begin_clear   (begin_clear),
                .clear_active  (clear_active),
                .write_enable  (clear_write_enable),
                .write_address (clear_write_address),
                .clear_done    (clear_done)
        );

        word_reader #(
                .OFFSET_WIDTH (OFFSET_WIDTH)
        ) u_word_reader (
                .clock        (clock),
                .reset_n      (reset_n),
                .begin_read   (begin_read),
                .read_active  (read_active),
                .word_address (argument_1[ADDRESS_WIDTH-1:0]),  // low bits carry the word address.
                .memory_data  (memory_data),
                .read_address (reader_read_address),
                .read_done    (read_done),
                .read_data    (memory_read_data)
        );

        bit_memory #(
                .OFFSET_WIDTH (OFFSET_WIDTH)
        ) u_bit_memory (
                .clock               (clock),
                .compute_active      (compute_active),
                .mark_write_enable   (mark_write_enable),
                .mark_write_address  (mark_write_address),
                .mark_write_data     (mark_write_data),
                .clear_write_enable  (clear_write_enable),
                .clear_write_address (clear_write_address),
                .mark_read_address   (mark_read_address),
                .reader_read_address (reader_read_address),
                .read_data           (memory_data)
        );

endmodule

// ==== tests/pe_stimulus_table.svh ====
// Fixed command entries for the processing element testbench, included inside the testbench module.
// columns: command, argument_1 (step or word address), argument_2 (first), argument_3 (last),
// the hand-derived read word, and whether that word is known for the entry.
typedef struct packed {
        pe_command_t             command;
        logic [STEP_WIDTH-1:0]   argument_1;
        logic [OFFSET_WIDTH-1:0] argument_2;
        logic [OFFSET_WIDTH-1:0] argument_3;
        pe_word_t                expected;
        logic                    known;
} stimulus_entry_t;

localparam int FIXED_ENTRIES = 24;

localparam stimulus_entry_t FIXED_TABLE [FIXED_ENTRIES] = '{
        '{CMD_CLEAR,   11'd0,   14'd0,     14'd0,     32'h0000_0000, 1'b0},
        '{CMD_READ,    11'd0,   14'd0,     14'd0,     32'h0000_0000, 1'b1},
        '{CMD_READ,    11'd511, 14'd0,     14'd0,     32'h0000_0000, 1'b1},
        '{CMD_READ,    11'd137, 14'd0,     14'd0,     32'h0000_0000, 1'b1},
        '{CMD_READ,    11'd300, 14'd0,     14'd0,     32'h0000_0000, 1'b1},
        '{CMD_COMPUTE, 11'd100, 14'd70,    14'd120,   32'h0000_0000, 1'b0},  // only offset 70.
        '{CMD_READ,    11'd2,   14'd0,     14'd0,     32'h0000_0040, 1'b1},
        '{CMD_READ,    11'd3,   14'd0,     14'd0,     32'h0000_0000, 1'b1},
        '{CMD_COMPUTE, 11'd7,   14'd200,   14'd300,   32'h0000_0000, 1'b0},  // words 6 to 9.
        '{CMD_READ,    11'd5,   14'd0,     14'd0,     32'h0000_0000, 1'b1},
        '{CMD_READ,    11'd6,   14'd0,     14'd0,     32'h2040_8100, 1'b1},
        '{CMD_READ,    11'd7,   14'd0,     14'd0,     32'h0204_0810, 1'b1},
        '{CMD_READ,    11'd8,   14'd0,     14'd0,     32'h1020_4081, 1'b1},
        '{CMD_READ,    11'd9,   14'd0,     14'd0,     32'h0000_0408, 1'b1},
        '{CMD_READ,    11'd10,  14'd0,     14'd0,     32'h0000_0000, 1'b1},
        '{CMD_COMPUTE, 11'd5,   14'd250,   14'd270,   32'h0000_0000, 1'b0},  // overlaps words 7, 8.
        '{CMD_READ,    11'd6,   14'd0,     14'd0,     32'h2040_8100, 1'b1},
        '{CMD_READ,    11'd7,   14'd0,     14'd0,     32'h8604_0810, 1'b1},
        '{CMD_READ,    11'd8,   14'd0,     14'd0,     32'h1020_4291, 1'b1},
        '{CMD_READ,    11'd9,   14'd0,     14'd0,     32'h0000_0408, 1'b1},
        '{CMD_COMPUTE, 11'd1,   14'd0,     14'd0,     32'h0000_0000, 1'b0},
        '{CMD_COMPUTE, 11'd3,   14'd16380, 14'd16383, 32'h0000_0000, 1'b0},  // top of the range.
        '{CMD_READ,    11'd0,   14'd0,     14'd0,     32'h0000_0001, 1'b1},
        '{CMD_READ,    11'd511, 14'd0,     14'd0,     32'h9000_0000, 1'b1}
};

// ==== tests/processing_element_tb.sv ====
// Self-checking testbench for the processing element; run it as the top module of the file list.
module processing_element_tb;
        import pe_pkg::*;

        localparam int          STEP_WIDTH      = DEFAULT_STEP_WIDTH;
        localparam int          OFFSET_WIDTH    = DEFAULT_OFFSET_WIDTH;
        localparam int          ADDRESS_WIDTH   = OFFSET_WIDTH - BIT_INDEX_BITS;
        localparam int          DEPTH           = 2 ** ADDRESS_WIDTH;
        localparam int          LAST_OFFSET     = 2 ** OFFSET_WIDTH - 1;
        localparam int          CLOCK_PERIOD    = 8;
        localparam int          DRIVE_DELAY     = 2;
        localparam int          RESET_CYCLES    = 8;
        localparam int          READ_LATENCY    = 4;
        localparam int          CLEAR_LATENCY   = DEPTH + 1;
        localparam int          RANDOM_COMPUTES = 12;
        localparam int unsigned RANDOM_SEED     = 32'ha5ac_6511;

        `include "pe_stimulus_table.svh"

        logic                    clock;
        logic                    reset_n;
        logic                    start;
        pe_command_t             command;
        logic [STEP_WIDTH-1:0]   argument_1;
        logic [OFFSET_WIDTH-1:0] argument_2;
        logic [OFFSET_WIDTH-1:0] argument_3;
        pe_word_t                memory_read_data;
        logic                    command_done;

        stimulus_entry_t entries [$];
        pe_word_t        model [DEPTH];         // expected memory contents.
        int              error_count;
        int              watchdog_cycles;

        processing_element #(
                .STEP_WIDTH   (STEP_WIDTH),
                .OFFSET_WIDTH (OFFSET_WIDTH)
        ) u_processing_element (
                .clock            (clock),
                .reset_n          (reset_n),
                .start            (start),
                .command          (command),
                .argument_1       (argument_1),
                .argument_2       (argument_2),
                .argument_3       (argument_3),
                .memory_read_data (memory_read_data),
                .command_done     (command_done)
        );

        initial begin
                clock = 1'b0;
                forever #(CLOCK_PERIOD / 2) clock = ~clock;
        end

        function automatic stimulus_entry_t read_entry(input int word, input logic known);
                stimulus_entry_t entry;
                entry            = '0;
                entry.command    = CMD_READ;
                entry.argument_1 = STEP_WIDTH'(word);
                entry.known      = known;         // a known entry expects zero here.
                return entry;
        endfunction

        // cycles allowed for one command, including the handshake turnaround.
        function automatic int cycle_budget(input stimulus_entry_t entry);
                int range;
                if (entry.command == CMD_CLEAR) begin
                        return 600;
                end
                range = 0;
                if (entry.command == CMD_COMPUTE) begin
                        range = (int'(entry.argument_3) - int'(entry.argument_2)) /
                                int'(entry.argument_1);
                end
                return 4 * (range + 2) + 20;
        endfunction

        task automatic build_entry_queue();
                stimulus_entry_t entry;
                int              first;
                int              last;
                int              n;
                foreach (FIXED_TABLE[i]) begin
                        entries.push_back(FIXED_TABLE[i]);
                end
                for (n = 0; n < RANDOM_COMPUTES; n++) begin
                        first = $urandom % (LAST_OFFSET + 1);
                        last  = first + $urandom % 2048;
                        if (last > LAST_OFFSET) begin
                                last = LAST_OFFSET;
                        end
                        entry            = '0;
                        entry.command    = CMD_COMPUTE;
                        entry.argument_1 = STEP_WIDTH'($urandom % (2 ** STEP_WIDTH - 1) + 1);
                        entry.argument_2 = OFFSET_WIDTH'(first);
                        entry.argument_3 = OFFSET_WIDTH'(last);
                        entries.push_back(entry);
                        entries.push_back(read_entry(first / WORD_BITS, 1'b0));
                        entries.push_back(read_entry(last / WORD_BITS, 1'b0));
                        entries.push_back(read_entry($urandom % DEPTH, 1'b0));
                end
                entry         = '0;
                entry.command = CMD_CLEAR;
                entries.push_back(entry);
                for (n = 0; n < DEPTH; n++) begin
                        entries.push_back(read_entry(n, 1'b1));    // every word is zero again.
                end
        endtask

        task automatic apply_to_model(input stimulus_entry_t entry);
                int offset;
                int word;
                if (entry.command == CMD_CLEAR) begin
                        for (word = 0; word < DEPTH; word++) begin
                                model[word] = '0;
                        end
                end else if (entry.command == CMD_COMPUTE) begin
                        offset = int'(entry.argument_2);
                        while (offset <= int'(entry.argument_3)) begin
                                model[offset / WORD_BITS][offset % WORD_BITS] = 1'b1;
                                offset += int'(entry.argument_1);
                        end
                end
        endtask

        task automatic run_entry(input stimulus_entry_t entry, input int index);
                pe_word_t expected;
                int       edge_count;
                expected = model[entry.argument_1[ADDRESS_WIDTH-1:0]];
                if (entry.command == CMD_READ && entry.known && expected !== entry.expected) begin
                        error_count++;
                        $display("entry %0d: reference model and stimulus table disagree", index);
                end
                @(posedge clock);
                #DRIVE_DELAY;
                command    = entry.command;
                argument_1 = entry.argument_1;
                argument_2 = entry.argument_2;
                argument_3 = entry.argument_3;
                start      = 1'b1;
                edge_count = -1;                // the next rising edge is edge E.
                do begin
                        @(posedge clock);
                        edge_count++;
                        @(negedge clock);
                end while (command_done !== 1'b1);
                apply_to_model(entry);
                if (entry.command == CMD_READ && edge_count != READ_LATENCY) begin
                        error_count++;
                        $display("entry %0d: read finished at E+%0d instead of E+%0d",
                                 index, edge_count, READ_LATENCY);
                end
                if (entry.command == CMD_READ && memory_read_data !== expected) begin
                        error_count++;
                        $display("MISMATCH entry %0d memory_read_data: got %h, expected %h",
                                 index, memory_read_data, expected);
                end
                if (entry.command == CMD_CLEAR && edge_count != CLEAR_LATENCY) begin
                        error_count++;
                        $display("entry %0d: clear finished at E+%0d instead of E+%0d",
                                 index, edge_count, CLEAR_LATENCY);
                end
                @(posedge clock);
                #DRIVE_DELAY;
                start = 1'b0;
                @(negedge clock);
                if (command_done !== 1'b0) begin
                        error_count++;
                        $display("entry %0d: command_done stayed high for a second cycle", index);
                end
        endtask

        initial begin
                error_count     = 0;
                watchdog_cycles = 0;
                reset_n         = 1'b0;
                start           = 1'b0;
                command         = CMD_COMPUTE;
                argument_1      = '0;
                argument_2      = '0;
                argument_3      = '0;
                void'($urandom(RANDOM_SEED));
                build_entry_queue();
                repeat (RESET_CYCLES) @(posedge clock);
                #DRIVE_DELAY;
                reset_n = 1'b1;
                @(negedge clock);
                if (command_done !== 1'b0) begin
                        error_count++;
                        $display("MISMATCH after reset command_done: got %h, expected 0",
                                 command_done);
                end
                if (memory_read_data !== '0) begin
                        error_count++;
                        $display("MISMATCH after reset memory_read_data: got %h, expected %h",
                                 memory_read_data, 32'h0);
                end
                foreach (entries[i]) begin
                        run_entry(entries[i], i);
                end
                $display("%0d errors over %0d commands", error_count, entries.size());
                if (error_count == 0) begin
                        $display("Testbench passed");
                end else begin
                        $display("Testbench failed");
                end
                $finish;
        end

        // the limit covers reset plus the budget of every queued command.
        initial begin
                int total;
                wait (entries.size() > 0);
                total = RESET_CYCLES + 20;
                foreach (entries[i]) begin
                        total += cycle_budget(entries[i]);
                end
                watchdog_cycles = total;
                repeat (watchdog_cycles) @(posedge clock);
                $display("timeout: commands did not complete within %0d cycles", watchdog_cycles);
                $display("%0d errors before the timeout", error_count);
                $display("Testbench failed");
                $finish;
        end

endmodule

// ==== processing_element.f ====
+incdir+tests
hw/pe_pkg.sv
hw/command_sequencer.sv
hw/mark_engine.sv
hw/clear_engine.sv
hw/word_reader.sv
hw/bit_memory.sv
hw/processing_element.sv
tests/processing_element_tb.sv
